/* common/controlPkg.sv */
`default_nettype none

package controlPkg;

	//**************************************************************************
	// instruction word fields
	//**************************************************************************
	localparam int opcodeLsb   = 0;
	localparam int funct3Lsb   = 12;
	localparam int funct7Lsb   = 25;
	localparam int opcodeWidth = 7;
	localparam int funct3Width = 3;
	localparam int funct7Width = 7;

	// major opcodes
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opSystem = 7'b1110011;

	localparam logic [2:0] funct3AddSub = 3'b000;	// add, sub, addi
	localparam logic [2:0] funct3Slt    = 3'b010;	// slt, slti
	localparam logic [2:0] funct3And    = 3'b111;
	localparam logic [2:0] funct3Beq    = 3'b000;
	localparam logic [2:0] funct3Bne    = 3'b001;
	localparam logic [2:0] funct3Blt    = 3'b100;
	localparam logic [2:0] funct3Bge    = 3'b101;
	localparam logic [2:0] funct3Double = 3'b011;	// ld and sd
	localparam logic [2:0] funct3Jalr   = 3'b000;

	localparam logic [6:0] funct7Base = 7'b0000000;
	localparam logic [6:0] funct7Sub  = 7'b0100000;

	//**************************************************************************
	// decoded class and sequencer state
	//**************************************************************************
	// 17 classes so one bit more than a nibble
	typedef enum logic [4:0] {
		clsAdd, clsSub, clsAnd, clsSlt,
		clsAddi, clsSlti,
		clsBeq, clsBne, clsBge, clsBlt,
		clsLui, clsLd, clsSd,
		clsJal, clsJalr,
		clsBreak, clsNone
	} instrClass_e;

	typedef enum logic [4:0] {
		stReset, stFetch, stDecode,
		stAluExec, stRegWrite,
		stCompare, stLessOne, stLessZero, stBranchTaken,
		stLoadAddr, stLoadWrite,
		stStoreAddr, stStoreWrite,
		stJalLink, stJalrAddr, stJalrJump, stJumpDone,
		stHalt
	} ctrlState_e;

	//**************************************************************************
	// datapath selectors
	//**************************************************************************
	typedef enum logic [2:0] {
		aluNone    = 3'd0,
		aluAdd     = 3'd1,
		aluSub     = 3'd2,
		aluAnd     = 3'd3,
		aluCompare = 3'd6
	} aluOp_e;

	typedef enum logic [1:0] {srcAPc, srcARegA, srcAZero} srcASel_e;
	typedef enum logic [1:0] {srcBFour, srcBRegB, srcBImm} srcBSel_e;
	typedef enum logic [2:0] {wbAluOut, wbMem, wbPc, wbZero, wbOne} wbSel_e;
	typedef enum logic [2:0] {immNone, immI, immB, immU, immS, immJ} immKind_e;
	typedef enum logic {pcAlu, pcAluOut} pcSel_e;

	// one control word per cycle
	typedef struct packed {
		logic     pcWrite;
		logic     instrWrite;
		logic     regAWrite;
		logic     regBWrite;
		logic     aluOutWrite;
		logic     regFileWrite;
		logic     mem64Write;
		aluOp_e   aluOp;
		srcASel_e srcA;
		srcBSel_e srcB;
		wbSel_e   wbSel;
		immKind_e immKind;
		pcSel_e   pcSel;
	} ctrlWord_t;

	typedef struct packed {
		logic equal;
		logic less;	// signed a < b from the compare
	} aluFlags_t;

endpackage

`default_nettype wire

/* files.f */
+incdir+verification
common/controlPkg.sv
rtl/instrDecoder.sv
sequencer/controlSequencer.sv
rtl/controlEncoder.sv
rtl/controlUnit.sv
verification/controlUnitTb.sv

/* rtl/controlEncoder.sv */
`default_nettype none
`timescale 1ns/1ps

module controlEncoder (
	input  controlPkg::ctrlState_e  state,
	input  controlPkg::instrClass_e heldClass,
	output controlPkg::ctrlWord_t   ctrl
);
	import controlPkg::*;

	always_comb
	begin
		ctrl = '0;	// all strobes low and selectors at zero
		case (state)
			stFetch:
			begin
				ctrl.pcWrite     = 1'b1;
				ctrl.instrWrite  = 1'b1;
				ctrl.aluOutWrite = 1'b1;
				ctrl.aluOp       = aluAdd;	// pc + 4
			end
			stDecode:
			begin
				ctrl.regAWrite = 1'b1;
				ctrl.regBWrite = 1'b1;
				case (heldClass)
					clsBeq, clsBne, clsBge, clsBlt:
						ctrl.immKind = immB;
					clsJal:
						ctrl.immKind = immJ;
					clsJalr:
						ctrl.immKind = immI;
					default:
						ctrl.immKind = immNone;
				endcase
				// jump and branch target from pc and immediate
				if (ctrl.immKind != immNone)
				begin
					ctrl.aluOp       = aluAdd;
					ctrl.srcA        = srcAPc;
					ctrl.srcB        = srcBImm;
					ctrl.aluOutWrite = 1'b1;
				end
			end

			//******************************************************************
			// arithmetic and compare
			//******************************************************************
			stAluExec:
			begin
				ctrl.aluOutWrite = 1'b1;
				ctrl.srcA        = srcARegA;
				ctrl.srcB        = srcBRegB;
				case (heldClass)
					clsSub:
						ctrl.aluOp = aluSub;
					clsAnd:
						ctrl.aluOp = aluAnd;
					clsAddi:
					begin
						ctrl.aluOp   = aluAdd;
						ctrl.srcB    = srcBImm;
						ctrl.immKind = immI;
					end
					clsLui:
					begin
						ctrl.aluOp   = aluAdd;	// 0 + upper immediate
						ctrl.srcA    = srcAZero;
						ctrl.srcB    = srcBImm;
						ctrl.immKind = immU;
					end
					default:
						ctrl.aluOp = aluAdd;
				endcase
			end
			stRegWrite:
			begin
				ctrl.regFileWrite = 1'b1;
				ctrl.wbSel        = wbAluOut;
			end
			stCompare:
			begin
				ctrl.aluOp = aluCompare;	// flags valid this cycle
				ctrl.srcA  = srcARegA;
				ctrl.srcB  = srcBRegB;
				case (heldClass)
					clsSlti:
					begin
						ctrl.srcB    = srcBImm;
						ctrl.immKind = immI;
					end
					clsBeq, clsBne, clsBge, clsBlt:
						ctrl.immKind = immB;
					default:
						ctrl.immKind = immNone;
				endcase
			end
			stLessOne:
			begin
				ctrl.regFileWrite = 1'b1;
				ctrl.wbSel        = wbOne;
			end
			stLessZero:
			begin
				ctrl.regFileWrite = 1'b1;
				ctrl.wbSel        = wbZero;
			end
			stBranchTaken:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSel   = pcAluOut;	// target from decode
			end

			//******************************************************************
			// memory and jumps
			//******************************************************************
			stLoadAddr, stStoreAddr:
			begin
				ctrl.aluOp       = aluAdd;	// rs1 + offset
				ctrl.srcA        = srcARegA;
				ctrl.srcB        = srcBImm;
				ctrl.aluOutWrite = 1'b1;
				ctrl.immKind     = (state == stStoreAddr) ? immS : immI;
			end
			stLoadWrite:
			begin
				ctrl.regFileWrite = 1'b1;
				ctrl.wbSel        = wbMem;
			end
			stStoreWrite:
				ctrl.mem64Write = 1'b1;
			stJalLink:
			begin
				ctrl.regFileWrite = 1'b1;
				ctrl.wbSel        = wbPc;	// link the return address
				ctrl.pcWrite      = 1'b1;
				ctrl.pcSel        = pcAluOut;
			end
			stJalrAddr:
			begin
				ctrl.aluOp        = aluAdd;
				ctrl.srcA         = srcARegA;
				ctrl.srcB         = srcBImm;
				ctrl.immKind      = immI;
				ctrl.aluOutWrite  = 1'b1;
				ctrl.regFileWrite = 1'b1;
				ctrl.wbSel        = wbPc;
			end
			stJalrJump:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSel   = pcAluOut;
			end
			default:
				ctrl = '0;	// reset, jump done and halt
		endcase
	end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`default_nettype none
`timescale 1ns/1ps

module controlUnit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           instruction,
	input  controlPkg::aluFlags_t flags,
	output controlPkg::ctrlWord_t ctrl
);
	import controlPkg::*;

	instrClass_e instClass;	// straight from the decoder
	instrClass_e heldClass;
	ctrlState_e  state;

	instrDecoder decoder_i (
		.instruction (instruction),
		.instClass   (instClass)
	);

	controlSequencer sequencer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.instClass (instClass),
		.flags     (flags),
		.state     (state),
		.heldClass (heldClass)
	);

	controlEncoder encoder_i (
		.state     (state),
		.heldClass (heldClass),
		.ctrl      (ctrl)
	);

endmodule

`default_nettype wire

/* rtl/instrDecoder.sv */
`default_nettype none
`timescale 1ns/1ps

module instrDecoder (
	input  logic [31:0]             instruction,
	output controlPkg::instrClass_e instClass
);
	import controlPkg::*;

	logic [opcodeWidth-1:0] opcode;
	logic [funct3Width-1:0] funct3;
	logic [funct7Width-1:0] funct7;

	assign opcode = instruction[opcodeLsb +: opcodeWidth];
	assign funct3 = instruction[funct3Lsb +: funct3Width];
	assign funct7 = instruction[funct7Lsb +: funct7Width];

	always_comb
	begin
		instClass = clsNone;	// unknown words fall back to fetch
		case (opcode)
			opR:
			begin
				case (funct3)
					funct3AddSub:
					begin
						if (funct7 == funct7Base)
							instClass = clsAdd;
						else if (funct7 == funct7Sub)
							instClass = clsSub;
					end
					funct3Slt:
						instClass = clsSlt;	// funct7 not checked
					funct3And:
						instClass = clsAnd;
					default:
						instClass = clsNone;
				endcase
			end
			opImm:
			begin
				if (funct3 == funct3AddSub)
					instClass = clsAddi;
				else if (funct3 == funct3Slt)
					instClass = clsSlti;	// shifts are not supported
			end
			opBranch:
			begin
				case (funct3)
					funct3Beq:
						instClass = clsBeq;
					funct3Bne:
						instClass = clsBne;
					funct3Blt:
						instClass = clsBlt;
					funct3Bge:
						instClass = clsBge;
					default:
						instClass = clsNone;
				endcase
			end
			opJalr:
			begin
				if (funct3 == funct3Jalr)
					instClass = clsJalr;
			end
			opLoad:
			begin
				if (funct3 == funct3Double)
					instClass = clsLd;	// only the 64-bit load
			end
			opStore:
			begin
				if (funct3 == funct3Double)
					instClass = clsSd;
			end
			opLui:
				instClass = clsLui;
			opJal:
				instClass = clsJal;
			opSystem:
				instClass = clsBreak;	// any system word halts
			default:
				instClass = clsNone;
		endcase
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile with Verilator and run the control unit testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module controlUnitTb -f files.f \
	-o controlUnitSim

./obj_dir/controlUnitSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi

/* sequencer/controlSequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module controlSequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  controlPkg::instrClass_e instClass,
	input  controlPkg::aluFlags_t   flags,
	output controlPkg::ctrlState_e  state,
	output controlPkg::instrClass_e heldClass
);
	import controlPkg::*;

	ctrlState_e  nextState;
	instrClass_e classReg;
	logic        branchTaken;

	//**************************************************************************
	// state and class registers
	//**************************************************************************
	always_ff @(posedge clk or posedge rst_n)
	begin
		if (rst_n)
			state <= stReset;
		else
			state <= nextState;
	end

	always_ff @(posedge clk or posedge rst_n)
	begin
		if (rst_n)
			classReg <= clsNone;
		else if (state == stDecode)
			classReg <= instClass;	// instruction free to change after decode
	end

	// live class during decode so the encoder sees it in the same cycle
	assign heldClass = (state == stDecode) ? instClass : classReg;

	// branch rule on the compare flags
	always_comb
	begin
		case (classReg)
			clsBeq:
				branchTaken = flags.equal;
			clsBne:
				branchTaken = ~flags.equal;
			clsBlt:
				branchTaken = flags.less;
			clsBge:
				branchTaken = ~flags.less;
			default:
				branchTaken = 1'b0;
		endcase
	end

	//**************************************************************************
	// next state
	//**************************************************************************
	always_comb
	begin
		nextState = stFetch;
		case (state)
			stReset:
				nextState = stFetch;
			stFetch:
				nextState = stDecode;
			stDecode:
			begin
				case (instClass)
					clsAdd, clsSub, clsAnd, clsAddi, clsLui:
						nextState = stAluExec;
					clsSlt, clsSlti, clsBeq, clsBne, clsBge, clsBlt:
						nextState = stCompare;
					clsLd:
						nextState = stLoadAddr;
					clsSd:
						nextState = stStoreAddr;
					clsJal:
						nextState = stJalLink;
					clsJalr:
						nextState = stJalrAddr;
					clsBreak:
						nextState = stHalt;
					default:
						nextState = stFetch;	// unknown opcode
				endcase
			end
			stAluExec:
				nextState = stRegWrite;
			stCompare:
			begin
				case (classReg)
					clsSlt, clsSlti:
					begin
						if (flags.less)
							nextState = stLessOne;
						else
							nextState = stLessZero;
					end
					default:
					begin
						if (branchTaken)
							nextState = stBranchTaken;
						else
							nextState = stFetch;	// not taken saves a cycle
					end
				endcase
			end
			stLoadAddr:
				nextState = stLoadWrite;
			stStoreAddr:
				nextState = stStoreWrite;
			stJalLink:
				nextState = stJumpDone;
			stJalrAddr:
				nextState = stJalrJump;
			stJalrJump:
				nextState = stJumpDone;
			stHalt:
				nextState = stHalt;	// left only through reset
			default:
				nextState = stFetch;
		endcase
	end

endmodule

`default_nettype wire

/* verification/controlModel.svh */
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

//****************************************************************************
// reference model of the control unit
//****************************************************************************

// strobes in order pc, ir, a, b, aluOut, regFile, mem64
function automatic ctrlWord_t packWord(input logic [6:0] strobes, input aluOp_e op,
		input srcASel_e a, input srcBSel_e b, input wbSel_e wb, input immKind_e imm,
		input pcSel_e pc);
	packWord = {strobes, op, a, b, wb, imm, pc};
endfunction

function automatic logic branchRule(input instrClass_e cls, input aluFlags_t f);
	case (cls)
		clsBeq:
			branchRule = f.equal;
		clsBne:
			branchRule = !f.equal;
		clsBlt:
			branchRule = f.less;
		clsBge:
			branchRule = !f.less;
		default:
			branchRule = 1'b0;
	endcase
endfunction

// cycles from one fetch to the next
function automatic int pathCycles(input instrClass_e cls, input logic taken);
	case (cls)
		clsBeq, clsBne, clsBge, clsBlt:
			pathCycles = taken ? 4 : 3;
		clsJalr:
			pathCycles = 5;
		clsNone:
			pathCycles = 2;	// fetch and decode only
		default:
			pathCycles = 4;
	endcase
endfunction

function automatic ctrlState_e modelNext(input ctrlState_e st, input instrClass_e cls,
		input aluFlags_t f);
	modelNext = stFetch;	// write-back and done states end here
	case (st)
		stReset:
			modelNext = stFetch;
		stFetch:
			modelNext = stDecode;
		stDecode:
		begin
			if (cls inside {clsAdd, clsSub, clsAnd, clsAddi, clsLui})
				modelNext = stAluExec;
			else if (cls inside {clsSlt, clsSlti, clsBeq, clsBne, clsBge, clsBlt})
				modelNext = stCompare;
			else if (cls == clsLd)
				modelNext = stLoadAddr;
			else if (cls == clsSd)
				modelNext = stStoreAddr;
			else if (cls == clsJal)
				modelNext = stJalLink;
			else if (cls == clsJalr)
				modelNext = stJalrAddr;
			else if (cls == clsBreak)
				modelNext = stHalt;
		end
		stAluExec:
			modelNext = stRegWrite;
		stCompare:
		begin
			if (cls == clsSlt || cls == clsSlti)
				modelNext = f.less ? stLessOne : stLessZero;
			else if (branchRule(cls, f))
				modelNext = stBranchTaken;
		end
		stLoadAddr:
			modelNext = stLoadWrite;
		stStoreAddr:
			modelNext = stStoreWrite;
		stJalLink, stJalrJump:
			modelNext = stJumpDone;
		stJalrAddr:
			modelNext = stJalrJump;
		stHalt:
			modelNext = stHalt;
		default:
			modelNext = stFetch;
	endcase
endfunction

function automatic ctrlWord_t expectedCtrl(input ctrlState_e st, input instrClass_e cls);
	immKind_e imm;
	expectedCtrl = '0;
	case (st)
		stFetch:
			expectedCtrl = packWord(7'b1100100, aluAdd, srcAPc, srcBFour, wbAluOut, immNone, pcAlu);
		stDecode:
		begin
			case (cls)
				clsBeq, clsBne, clsBge, clsBlt:
					imm = immB;
				clsJal:
					imm = immJ;
				clsJalr:
					imm = immI;
				default:
					imm = immNone;
			endcase
			if (imm == immNone)
				expectedCtrl = packWord(7'b0011000, aluNone, srcAPc, srcBFour, wbAluOut, immNone,
					pcAlu);
			else
				expectedCtrl = packWord(7'b0011100, aluAdd, srcAPc, srcBImm, wbAluOut, imm, pcAlu);
		end
		stAluExec:
		begin
			case (cls)
				clsSub:
					expectedCtrl = packWord(7'b0000100, aluSub, srcARegA, srcBRegB, wbAluOut,
						immNone, pcAlu);
				clsAnd:
					expectedCtrl = packWord(7'b0000100, aluAnd, srcARegA, srcBRegB, wbAluOut,
						immNone, pcAlu);
				clsAddi:
					expectedCtrl = packWord(7'b0000100, aluAdd, srcARegA, srcBImm, wbAluOut, immI,
						pcAlu);
				clsLui:
					expectedCtrl = packWord(7'b0000100, aluAdd, srcAZero, srcBImm, wbAluOut, immU,
						pcAlu);
				default:
					expectedCtrl = packWord(7'b0000100, aluAdd, srcARegA, srcBRegB, wbAluOut,
						immNone, pcAlu);
			endcase
		end
		stRegWrite:
			expectedCtrl = packWord(7'b0000010, aluNone, srcAPc, srcBFour, wbAluOut, immNone, pcAlu);
		stCompare:
		begin
			if (cls == clsSlti)
				expectedCtrl = packWord(7'b0, aluCompare, srcARegA, srcBImm, wbAluOut, immI, pcAlu);
			else if (cls inside {clsBeq, clsBne, clsBge, clsBlt})
				expectedCtrl = packWord(7'b0, aluCompare, srcARegA, srcBRegB, wbAluOut, immB,
					pcAlu);
			else
				expectedCtrl = packWord(7'b0, aluCompare, srcARegA, srcBRegB, wbAluOut, immNone,
					pcAlu);
		end
		stLessOne:
			expectedCtrl = packWord(7'b0000010, aluNone, srcAPc, srcBFour, wbOne, immNone, pcAlu);
		stLessZero:
			expectedCtrl = packWord(7'b0000010, aluNone, srcAPc, srcBFour, wbZero, immNone, pcAlu);
		stBranchTaken, stJalrJump:
			expectedCtrl = packWord(7'b1000000, aluNone, srcAPc, srcBFour, wbAluOut, immNone,
				pcAluOut);
		stLoadAddr:
			expectedCtrl = packWord(7'b0000100, aluAdd, srcARegA, srcBImm, wbAluOut, immI, pcAlu);
		stStoreAddr:
			expectedCtrl = packWord(7'b0000100, aluAdd, srcARegA, srcBImm, wbAluOut, immS, pcAlu);
		stLoadWrite:
			expectedCtrl = packWord(7'b0000010, aluNone, srcAPc, srcBFour, wbMem, immNone, pcAlu);
		stStoreWrite:
			expectedCtrl = packWord(7'b0000001, aluNone, srcAPc, srcBFour, wbAluOut, immNone,
				pcAlu);
		stJalLink:
			expectedCtrl = packWord(7'b1000010, aluNone, srcAPc, srcBFour, wbPc, immNone, pcAluOut);
		stJalrAddr:
			expectedCtrl = packWord(7'b0000110, aluAdd, srcARegA, srcBImm, wbPc, immI, pcAlu);
		default:
			expectedCtrl = '0;	// reset, jump done, halt
	endcase
endfunction

`endif

/* verification/controlUnitTb.sv */
`default_nettype none
`timescale 1ns/1ps

module controlUnitTb;
	import controlPkg::*;

	`include "controlModel.svh"

	logic        clk = 1'b0;
	logic        rst_n;
	logic [31:0] instruction;
	aluFlags_t   flags;
	ctrlWord_t   ctrl;

	ctrlState_e  curState;	// model state of the cycle just checked
	ctrlState_e  upcoming = stReset;
	instrClass_e pendClass = clsNone;	// class of the word fetched last
	instrClass_e heldModel = clsNone;
	logic        lastTaken = 1'b0;

	controlUnit dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instruction (instruction),
		.flags       (flags),
		.ctrl        (ctrl)
	);

	always #2 clk = ~clk;

	function automatic logic isKnownOp(input logic [6:0] op);
		isKnownOp = op inside {opR, opImm, opBranch, opJalr, opLui, opLoad, opStore, opJal,
			opSystem};
	endfunction

	//************************************************************************
	// random instruction words
	//************************************************************************
	task automatic genInstr(output logic [31:0] word, output instrClass_e cls);
		logic [31:0] r;
		logic [6:0]  op;
		int unsigned kind;
		r = $urandom;
		kind = $urandom % 18;
		cls = clsNone;
		case (kind)
			0:
			begin
				word = {funct7Base, r[24:15], funct3AddSub, r[11:7], opR};
				cls = clsAdd;
			end
			1:
			begin
				word = {funct7Sub, r[24:15], funct3AddSub, r[11:7], opR};
				cls = clsSub;
			end
			2:
			begin
				word = {r[31:25], r[24:15], funct3And, r[11:7], opR};	// any funct7
				cls = clsAnd;
			end
			3:
			begin
				word = {r[31:25], r[24:15], funct3Slt, r[11:7], opR};
				cls = clsSlt;
			end
			4:
			begin
				word = {r[31:15], funct3AddSub, r[11:7], opImm};
				cls = clsAddi;
			end
			5:
			begin
				word = {r[31:15], funct3Slt, r[11:7], opImm};
				cls = clsSlti;
			end
			6:
			begin
				word = {r[31:15], funct3Beq, r[11:7], opBranch};
				cls = clsBeq;
			end
			7:
			begin
				word = {r[31:15], funct3Bne, r[11:7], opBranch};
				cls = clsBne;
			end
			8:
			begin
				word = {r[31:15], funct3Bge, r[11:7], opBranch};
				cls = clsBge;
			end
			9:
			begin
				word = {r[31:15], funct3Blt, r[11:7], opBranch};
				cls = clsBlt;
			end
			10:
			begin
				word = {r[31:7], opLui};
				cls = clsLui;
			end
			11:
			begin
				word = {r[31:15], funct3Double, r[11:7], opLoad};
				cls = clsLd;
			end
			12:
			begin
				word = {r[31:15], funct3Double, r[11:7], opStore};
				cls = clsSd;
			end
			13:
			begin
				word = {r[31:7], opJal};
				cls = clsJal;
			end
			14:
			begin
				word = {r[31:15], funct3Jalr, r[11:7], opJalr};
				cls = clsJalr;
			end
			15:
			begin
				op = r[6:0];
				while (isKnownOp(op))
					op = op + 7'd1;
				word = {r[31:7], op};	// opcode outside the set
			end
			16:
			begin
				// dropped or undefined encodings of known opcodes
				case ($urandom % 4)
					0:
						word = {7'b0000001, r[24:15], 3'b000, r[11:7], opR};
					1:
						word = {r[31:15], 3'b001, r[11:7], opImm};
					2:
						word = {r[31:15], 3'b010, r[11:7], opLoad};
					default:
						word = {r[31:15], 3'b010, r[11:7], opBranch};
				endcase
			end
			default:
			begin
				word = 32'h0010_0073;	// ebreak
				cls = clsBreak;
			end
		endcase
	endtask

	//************************************************************************
	// one clock cycle with drive, check and model step
	//************************************************************************
	task automatic runCycle(input logic rstVal);
		logic [31:0] word;
		logic [31:0] r;
		instrClass_e cls;
		ctrlWord_t   expected;
		@(posedge clk);
		r = $urandom;
		rst_n <= rstVal;
		flags.equal <= r[0];
		flags.less <= r[1];
		if (upcoming == stFetch)
		begin
			genInstr(word, cls);
			instruction <= word;
			pendClass = cls;
		end
		else if (upcoming != stDecode)
			instruction <= $urandom;	// noise outside fetch and decode
		@(negedge clk);
		curState = rst_n ? stReset : upcoming;
		if (curState == stDecode)
			heldModel = pendClass;
		expected = expectedCtrl(curState, heldModel);
		assert (ctrl == expected)
		else
		begin
			$display("Error ctrl: got %h, expected %h", ctrl, expected);
			$display("Test FAILED");
			$fatal(1, "control word mismatch");
		end
		if (curState == stCompare)
			lastTaken = branchRule(heldModel, flags);
		upcoming = rst_n ? stReset : modelNext(curState, heldModel, flags);
	endtask

	// counts cycles until the DUT itself shows a fetch
	task automatic waitFetch(output int cycles);
		cycles = 0;
		do
		begin
			runCycle(1'b0);
			cycles++;
		end
		while (!ctrl.instrWrite && cycles < 16);
		assert (ctrl.instrWrite)
		else
		begin
			$display("Timeout: no fetch within 16 cycles");
			$display("Test FAILED");
			$fatal(1, "fetch timeout");
		end
	endtask

	initial
	begin
		int          cycles;
		instrClass_e prevClass;
		void'($urandom(32'h2a37_17fb));
		rst_n = 1'b1;
		instruction = '0;
		flags = '0;
		runCycle(1'b1);
		runCycle(1'b1);
		waitFetch(cycles);
		// release cycle still in reset, fetch right after it
		assert (cycles == 2)
		else
		begin
			$display("Error cycles: got %h, expected %h", cycles, 2);
			$display("Test FAILED");
			$fatal(1, "no fetch after reset");
		end
		for (int n = 0; n < 400; n++)
		begin
			prevClass = pendClass;
			if (prevClass == clsBreak)
			begin
				repeat (6)
					runCycle(1'b0);	// decode, then halt with all strobes low
				runCycle(1'b1);
				runCycle(1'b1);
				waitFetch(cycles);
			end
			else
			begin
				waitFetch(cycles);
				assert (cycles == pathCycles(prevClass, lastTaken))
				else
				begin
					$display("Error cycles: got %h, expected %h", cycles,
						pathCycles(prevClass, lastTaken));
					$display("Test FAILED");
					$fatal(1, "wrong path length");
				end
			end
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
